// ==== sim.f ====
dcache_pkg.sv
ram_port_if.sv
miss_if.sv
tag_array.sv
line_state.sv
data_ram.sv
req_pipe.sv
miss_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dcache
SEED      ?= 72975
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) -Mdir $(OBJ_DIR) -f sim.f

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "=== PASS ===" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_dcache.sv ====
`timescale 1ns/100ps

module tb_dcache;
    parameter int SEED = 72975;

    localparam int CLK_PERIOD  = 10;
    localparam int LINE_WORDS  = 16;
    localparam int N_RANDOM    = 300;
    localparam int N_OPS       = N_RANDOM + 40;
    // victim read plus two stalled bursts, with margin
    localparam int MISS_CYCLES = 200;
    localparam dcache_pkg::addr_t LINE_MASK = ~dcache_pkg::addr_t'(LINE_WORDS * 4 - 1);

    typedef struct packed {
        dcache_pkg::word_t expected;
        logic              is_read;
        logic              want_hit;
        int                accept_cycle;
    } resp_t;

    logic                   clk;
    logic                   resetn;
    logic                   req_valid;
    dcache_pkg::addr_t      req_addr;
    dcache_pkg::strb_t      req_strobe;
    dcache_pkg::word_t      req_wdata;
    logic                   req_uncached;
    logic                   addr_ok;
    logic                   data_ok;
    dcache_pkg::word_t      rdata;
    logic                   mem_valid;
    logic                   mem_is_write;
    dcache_pkg::addr_t      mem_addr;
    dcache_pkg::burst_len_t mem_len;
    dcache_pkg::strb_t      mem_strobe;
    dcache_pkg::word_t      mem_wdata;
    logic                   mem_ready;
    logic                   mem_last;
    dcache_pkg::word_t      mem_rdata;
    int                     beat_idx;
    int                     line_reads;
    int                     line_writes;
    int                     singles;

    dcache_pkg::word_t shadow [dcache_pkg::addr_t];
    resp_t             pending [$];
    int                cycle = 0;
    bit                expect_hit;
    dcache_pkg::addr_t last_addr;
    dcache_pkg::addr_t fill_addr_seen;
    dcache_pkg::addr_t single_addr;
    dcache_pkg::strb_t single_strobe;
    dcache_pkg::word_t single_wdata;
    logic              single_write;

    dcache_top #(.SET_NUM(16), .LINE_WORDS(LINE_WORDS)) u_dut (
        .clk, .resetn, .req_valid, .req_addr, .req_strobe, .req_wdata, .req_uncached,
        .addr_ok, .data_ok, .rdata, .mem_valid, .mem_is_write, .mem_addr, .mem_len,
        .mem_strobe, .mem_wdata, .mem_ready, .mem_last, .mem_rdata
    );

    tb_mem_model #(.LINE_WORDS(LINE_WORDS)) u_mem (
        .clk, .mem_valid, .mem_is_write, .mem_addr, .mem_len, .mem_strobe, .mem_wdata,
        .mem_ready, .mem_last, .mem_rdata, .beat_idx, .line_reads, .line_writes, .singles
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic dcache_pkg::word_t fill_pattern(dcache_pkg::addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic dcache_pkg::word_t ref_read(dcache_pkg::addr_t a);
        dcache_pkg::addr_t w;
        w = {a[31:2], 2'b00};
        if (shadow.exists(w)) begin
            return shadow[w];
        end
        return fill_pattern(w);
    endfunction

    function automatic dcache_pkg::word_t merge_bytes(dcache_pkg::word_t old,
                                                      dcache_pkg::strb_t s,
                                                      dcache_pkg::word_t d);
        for (int b = 0; b < dcache_pkg::STRB_BITS; b++) begin
            if (s[b]) begin
                old[8*b +: 8] = d[8*b +: 8];
            end
        end
        return old;
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("error %s expected %h got %h", name, expected, actual));
        end
    endtask

    // called at a rising edge, returns at the accepting edge
    task automatic issue(input dcache_pkg::addr_t a, input dcache_pkg::strb_t s,
                         input dcache_pkg::word_t d, input bit unc);
        resp_t r;
        #1;
        req_valid    = 1'b1;
        req_addr     = a;
        req_strobe   = s;
        req_wdata    = d;
        req_uncached = unc;
        do begin
            @(posedge clk);
        end while (addr_ok !== 1'b1);
        last_addr = a;
        if (s != '0) begin
            shadow[{a[31:2], 2'b00}] = merge_bytes(ref_read(a), s, d);
        end
        r.expected     = ref_read(a);
        r.is_read      = (s == '0);
        r.want_hit     = expect_hit;
        r.accept_cycle = cycle;
        pending.push_back(r);
    endtask

    task automatic idle_cycles(input int n);
        #1;
        req_valid = 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic drain();
        #1;
        req_valid = 1'b0;
        while (pending.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        resp_t r;
        if (resetn == 1'b0 && data_ok === 1'b1) begin
            if (pending.size() == 0) begin
                report_failure("data_ok came with no request outstanding");
            end else begin
                r = pending.pop_front();
                if (r.is_read) begin
                    check_value("rdata", r.expected, rdata);
                end
                if (r.want_hit) begin
                    check_value("data_ok_latency", 32'd2, 32'(cycle - r.accept_cycle));
                end
            end
        end
    end

    // refills follow the missing request and writebacks carry shadow data
    always @(posedge clk) begin
        if (resetn == 1'b0 && mem_valid === 1'b1 && mem_ready === 1'b1) begin
            if (mem_len == dcache_pkg::LEN_LINE) begin
                if (mem_is_write) begin
                    check_value("mem_wdata", ref_read(mem_addr + 32'(4 * beat_idx)),
                                mem_wdata);
                end else begin
                    check_value("mem_addr", last_addr & LINE_MASK, mem_addr);
                    if (beat_idx == 0) begin
                        fill_addr_seen = mem_addr;
                    end
                end
            end else begin
                single_addr   = mem_addr;
                single_strobe = mem_strobe;
                single_wdata  = mem_wdata;
                single_write  = mem_is_write;
            end
        end
    end

    initial begin
        #(N_OPS * MISS_CYCLES * CLK_PERIOD);
        report_failure("timeout, the cache stopped answering requests");
    end

    initial begin
        dcache_pkg::addr_t base;
        dcache_pkg::addr_t a;
        dcache_pkg::strb_t s;
        int                reads0;
        int                writes0;
        int                singles0;
        void'($urandom(SEED));
        clk          = 1'b0;
        resetn       = 1'b1;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_strobe   = '0;
        req_wdata    = '0;
        req_uncached = 1'b0;
        expect_hit   = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        resetn = 1'b0;
        @(posedge clk);

        // cold miss fetches the whole line
        base   = 32'h0000_2040;
        reads0 = line_reads;
        issue(base + 32'h14, '0, '0, 1'b0);
        drain();
        check_value("line_reads", 32'(reads0 + 1), 32'(line_reads));
        check_value("fill_addr", base, fill_addr_seen);

        // back-to-back hits, no memory traffic
        reads0   = line_reads;
        writes0  = line_writes;
        singles0 = singles;
        expect_hit = 1'b1;
        for (int i = 0; i < LINE_WORDS; i++) begin
            issue(base + 32'(4 * i), '0, '0, 1'b0);
        end
        issue(base + 32'h4, 4'b0011, 32'h1122_3344, 1'b0);
        issue(base + 32'h8, 4'b1000, 32'haabb_ccdd, 1'b0);
        issue(base + 32'h4, '0, '0, 1'b0);
        issue(base + 32'hc, 4'b0110, 32'h5566_7788, 1'b0);
        issue(base + 32'h8, '0, '0, 1'b0);
        issue(base + 32'hc, '0, '0, 1'b0);
        drain();
        expect_hit = 1'b0;
        check_value("line_reads", 32'(reads0), 32'(line_reads));
        check_value("line_writes", 32'(writes0), 32'(line_writes));
        check_value("singles", 32'(singles0), 32'(singles));

        // third tag in the set evicts the dirty line
        issue(base + 32'h400, '0, '0, 1'b0);
        issue(base + 32'h800, '0, '0, 1'b0);
        drain();
        check_value("line_writes", 32'(writes0 + 1), 32'(line_writes));
        issue(base + 32'h4, '0, '0, 1'b0);
        issue(base + 32'h8, '0, '0, 1'b0);
        issue(base + 32'hc, '0, '0, 1'b0);
        drain();

        // uncached read and write, then a cached read of the same word
        a = 32'h0000_8010;
        issue(a, '0, '0, 1'b1);
        drain();
        check_value("mem_addr", a, single_addr);
        check_value("mem_is_write", 32'd0, 32'(single_write));
        issue(a, 4'b0110, 32'hdead_beef, 1'b1);
        drain();
        check_value("mem_addr", a, single_addr);
        check_value("mem_is_write", 32'd1, 32'(single_write));
        check_value("mem_strobe", 32'h6, 32'(single_strobe));
        check_value("mem_wdata", 32'hdead_beef, single_wdata);
        issue(a, '0, '0, 1'b0);
        drain();

        // random traffic over four tags in two sets
        for (int i = 0; i < N_RANDOM; i++) begin
            a = 32'h0001_0000 + (($urandom % 4) << 10) + (($urandom % 2) << 6)
                + (($urandom % LINE_WORDS) << 2);
            if ($urandom % 2 == 0) begin
                s = '0;
            end else begin
                s = dcache_pkg::strb_t'($urandom);
            end
            issue(a, s, $urandom, 1'b0);
            if ($urandom % 4 == 0) begin
                idle_cycles(1 + int'($urandom % 3));
            end
        end
        drain();

        $display("=== PASS ===");
        $finish;
    end
endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/100ps

module tb_mem_model #(
    parameter int LINE_WORDS = 16
) (
    input  logic                   clk,
    input  logic                   mem_valid,
    input  logic                   mem_is_write,
    input  dcache_pkg::addr_t      mem_addr,
    input  dcache_pkg::burst_len_t mem_len,
    input  dcache_pkg::strb_t      mem_strobe,
    input  dcache_pkg::word_t      mem_wdata,
    output logic                   mem_ready,
    output logic                   mem_last,
    output dcache_pkg::word_t      mem_rdata,
    output int                     beat_idx,
    output int                     line_reads,
    output int                     line_writes,
    output int                     singles
);
    dcache_pkg::word_t store [dcache_pkg::addr_t];
    int                beat_cnt = 0;
    int                n_rd     = 0;
    int                n_wr     = 0;
    int                n_single = 0;

    assign beat_idx    = beat_cnt;
    assign line_reads  = n_rd;
    assign line_writes = n_wr;
    assign singles     = n_single;

    // unwritten words hold a pattern of their own address
    function automatic dcache_pkg::word_t fill_pattern(dcache_pkg::addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic dcache_pkg::word_t read_word(dcache_pkg::addr_t a);
        if (store.exists(a)) begin
            return store[a];
        end
        return fill_pattern(a);
    endfunction

    function automatic dcache_pkg::addr_t beat_address();
        return {mem_addr[31:2] + 30'(beat_cnt), 2'b00};
    endfunction

    initial begin
        dcache_pkg::addr_t a;
        dcache_pkg::word_t w;
        mem_ready = 1'b0;
        mem_last  = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            a = beat_address();
            if (mem_valid && mem_ready) begin
                if (mem_is_write) begin
                    w = read_word(a);
                    for (int b = 0; b < dcache_pkg::STRB_BITS; b++) begin
                        if (mem_strobe[b]) begin
                            w[8*b +: 8] = mem_wdata[8*b +: 8];
                        end
                    end
                    store[a] = w;
                end
                if (mem_last) begin
                    beat_cnt <= 0;
                    if (mem_len == dcache_pkg::LEN_SINGLE) begin
                        n_single <= n_single + 1;
                    end else if (mem_is_write) begin
                        n_wr <= n_wr + 1;
                    end else begin
                        n_rd <= n_rd + 1;
                    end
                end else begin
                    beat_cnt <= beat_cnt + 1;
                end
            end
            #1;
            // ready three cycles in four
            mem_ready = ($urandom % 4) != 0;
            mem_last  = (mem_len == dcache_pkg::LEN_SINGLE) || (beat_cnt == LINE_WORDS - 1);
            mem_rdata = read_word(beat_address());
        end
    end
endmodule

// ==== dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top #(
    parameter int SET_NUM    = 16,
    parameter int LINE_WORDS = 16
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   req_valid,
    input  dcache_pkg::addr_t      req_addr,
    input  dcache_pkg::strb_t      req_strobe,
    input  dcache_pkg::word_t      req_wdata,
    input  logic                   req_uncached,
    output logic                   addr_ok,
    output logic                   data_ok,
    output dcache_pkg::word_t      rdata,
    output logic                   mem_valid,
    output logic                   mem_is_write,
    output dcache_pkg::addr_t      mem_addr,
    output dcache_pkg::burst_len_t mem_len,
    output dcache_pkg::strb_t      mem_strobe,
    output dcache_pkg::word_t      mem_wdata,
    input  logic                   mem_ready,
    input  logic                   mem_last,
    input  dcache_pkg::word_t      mem_rdata
);
    localparam int IDX_W  = $clog2(SET_NUM);
    localparam int TAG_W  = dcache_pkg::ADDR_BITS - IDX_W - $clog2(LINE_WORDS) - 2;
    localparam int RAM_AW = $clog2(dcache_pkg::WAYS) + IDX_W + $clog2(LINE_WORDS);

    logic                                   hit;
    logic                                   hit_way;
    logic [dcache_pkg::WAYS-1:0][TAG_W-1:0] way_tags;
    logic                                   victim_way;
    logic                                   victim_dirty;
    logic [IDX_W-1:0]                       query_set;
    logic [IDX_W-1:0]                       touch_set;
    logic                                   touch_en;
    logic                                   touch_way;
    logic                                   mark_dirty;
    logic                                   fill_en;
    dcache_pkg::addr_t                      fill_addr;
    logic                                   fill_way;

    miss_if #(.TAG_W(TAG_W)) miss ();
    ram_port_if #(.AW(RAM_AW)) ram_a ();
    ram_port_if #(.AW(RAM_AW)) ram_b ();

    tag_array #(.SET_NUM(SET_NUM), .LINE_WORDS(LINE_WORDS)) u_tags (
        .clk, .resetn, .lookup_addr(req_addr), .fill_en, .fill_addr, .fill_way,
        .hit, .hit_way, .way_tags
    );

    line_state #(.SET_NUM(SET_NUM)) u_state (
        .clk, .resetn, .query_set, .touch_en, .touch_set, .touch_way, .mark_dirty,
        .fill_en, .fill_way, .victim_way, .victim_dirty
    );

    data_ram #(.SET_NUM(SET_NUM), .LINE_WORDS(LINE_WORDS)) u_data (
        .clk, .port_a(ram_a.ram), .port_b(ram_b.ram)
    );

    req_pipe #(.SET_NUM(SET_NUM), .LINE_WORDS(LINE_WORDS)) u_pipe (
        .clk, .resetn, .req_valid, .req_addr, .req_strobe, .req_wdata, .req_uncached,
        .hit, .hit_way, .way_tags, .victim_way, .victim_dirty,
        .addr_ok, .data_ok, .rdata, .query_set, .touch_en, .touch_set, .touch_way,
        .mark_dirty, .ram_a(ram_a.user), .miss(miss.pipe)
    );

    miss_ctrl #(.SET_NUM(SET_NUM), .LINE_WORDS(LINE_WORDS)) u_miss (
        .clk, .resetn, .mem_ready, .mem_last, .mem_rdata,
        .mem_valid, .mem_is_write, .mem_addr, .mem_len, .mem_strobe, .mem_wdata,
        .fill_en, .fill_addr, .fill_way, .miss(miss.ctrl), .ram_b(ram_b.user)
    );
endmodule

// ==== miss_ctrl.sv ====
`timescale 1ns/100ps

module miss_ctrl #(
    parameter int  SET_NUM    = 16,
    parameter int  LINE_WORDS = 16,
    localparam int WI         = $clog2(LINE_WORDS),
    localparam int IDX_W      = $clog2(SET_NUM),
    localparam int OFF_W      = WI + 2,
    localparam int TAG_W      = dcache_pkg::ADDR_BITS - IDX_W - OFF_W
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   mem_ready,
    input  logic                   mem_last,
    input  dcache_pkg::word_t      mem_rdata,
    output logic                   mem_valid,
    output logic                   mem_is_write,
    output dcache_pkg::addr_t      mem_addr,
    output dcache_pkg::burst_len_t mem_len,
    output dcache_pkg::strb_t      mem_strobe,
    output dcache_pkg::word_t      mem_wdata,
    output logic                   fill_en,
    output dcache_pkg::addr_t      fill_addr,
    output logic                   fill_way,
    miss_if.ctrl                   miss,
    ram_port_if.user               ram_b
);
    dcache_pkg::miss_state_t state;
    dcache_pkg::addr_t       cur_addr;
    dcache_pkg::strb_t       cur_strobe;
    dcache_pkg::word_t       cur_wdata;
    logic                    cur_way;
    logic [TAG_W-1:0]        cur_tag;
    logic [WI:0]             rd_cnt;
    logic [WI-1:0]           beat;
    logic                    hold;
    logic                    beat_ok;
    logic                    is_unc;
    dcache_pkg::word_t       line_buf [LINE_WORDS];

    assign is_unc  = (state == dcache_pkg::UNCACHED);
    assign beat_ok = mem_valid & mem_ready;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state  <= dcache_pkg::IDLE;
            rd_cnt <= '0;
            beat   <= '0;
            hold   <= 1'b0;
        end else begin
            // one idle cycle on the bus between writeback and fetch
            hold <= (state == dcache_pkg::WRITEBACK) && beat_ok && mem_last;
            case (state)
                dcache_pkg::IDLE: begin
                    rd_cnt <= '0;
                    beat   <= '0;
                    if (miss.start) begin
                        if (miss.uncached) begin
                            state <= dcache_pkg::UNCACHED;
                        end else if (miss.victim_dirty) begin
                            state <= dcache_pkg::WB_READ;
                        end else begin
                            state <= dcache_pkg::FETCH;
                        end
                    end
                end
                dcache_pkg::WB_READ: begin
                    // last count only catches the final read word
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_cnt == (WI+1)'(LINE_WORDS)) begin
                        state <= dcache_pkg::WRITEBACK;
                    end
                end
                dcache_pkg::WRITEBACK: begin
                    if (beat_ok) begin
                        beat <= beat + 1'b1;
                        if (mem_last) begin
                            state <= dcache_pkg::FETCH;
                        end
                    end
                end
                dcache_pkg::FETCH: begin
                    if (beat_ok) begin
                        beat <= beat + 1'b1;
                        if (mem_last) begin
                            state <= dcache_pkg::IDLE;
                        end
                    end
                end
                dcache_pkg::UNCACHED: begin
                    if (beat_ok && mem_last) begin
                        state <= dcache_pkg::IDLE;
                    end
                end
                default: begin
                    state <= dcache_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == dcache_pkg::IDLE && miss.start) begin
            cur_addr   <= miss.addr;
            cur_strobe <= miss.strobe;
            cur_wdata  <= miss.wdata;
            cur_way    <= miss.victim_way;
            cur_tag    <= miss.victim_tag;
        end
        if (state == dcache_pkg::WB_READ && rd_cnt != '0) begin
            line_buf[WI'(rd_cnt - 1'b1)] <= ram_b.rdata;
        end
        if (is_unc && beat_ok && mem_last) begin
            miss.unc_rdata <= mem_rdata;
        end
    end

    always_comb begin
        mem_valid    = ~hold && (state == dcache_pkg::WRITEBACK ||
                                 state == dcache_pkg::FETCH || is_unc);
        mem_is_write = (state == dcache_pkg::WRITEBACK) || (is_unc && |cur_strobe);
        mem_len      = is_unc ? dcache_pkg::LEN_SINGLE : dcache_pkg::LEN_LINE;
        mem_strobe   = is_unc ? cur_strobe : {dcache_pkg::STRB_BITS{1'b1}};
        mem_wdata    = is_unc ? cur_wdata : line_buf[beat];
        if (is_unc) begin
            mem_addr = cur_addr;
        end else if (state == dcache_pkg::WRITEBACK) begin
            mem_addr = {cur_tag, cur_addr[OFF_W +: IDX_W], {OFF_W{1'b0}}};
        end else begin
            mem_addr = {cur_addr[dcache_pkg::ADDR_BITS-1:OFF_W], {OFF_W{1'b0}}};
        end
    end

    // port b reads the victim line, then takes the refill beats
    assign ram_b.en     = (state == dcache_pkg::WB_READ) ||
                          (state == dcache_pkg::FETCH && beat_ok);
    assign ram_b.strobe = {dcache_pkg::STRB_BITS{state == dcache_pkg::FETCH}};
    assign ram_b.addr   = {cur_way, cur_addr[OFF_W +: IDX_W],
                           (state == dcache_pkg::WB_READ) ? rd_cnt[WI-1:0] : beat};
    assign ram_b.wdata  = mem_rdata;

    assign miss.done = beat_ok && mem_last && (state == dcache_pkg::FETCH || is_unc);
    assign fill_en   = beat_ok && mem_last && (state == dcache_pkg::FETCH);
    assign fill_addr = cur_addr;
    assign fill_way  = cur_way;
endmodule

// ==== req_pipe.sv ====
`timescale 1ns/100ps

module req_pipe #(
    parameter int  SET_NUM    = 16,
    parameter int  LINE_WORDS = 16,
    localparam int WI         = $clog2(LINE_WORDS),
    localparam int IDX_W      = $clog2(SET_NUM),
    localparam int OFF_W      = WI + 2,
    localparam int TAG_W      = dcache_pkg::ADDR_BITS - IDX_W - OFF_W
) (
    input  logic                                   clk,
    input  logic                                   resetn,
    input  logic                                   req_valid,
    input  dcache_pkg::addr_t                      req_addr,
    input  dcache_pkg::strb_t                      req_strobe,
    input  dcache_pkg::word_t                      req_wdata,
    input  logic                                   req_uncached,
    input  logic                                   hit,
    input  logic                                   hit_way,
    input  logic [dcache_pkg::WAYS-1:0][TAG_W-1:0] way_tags,
    input  logic                                   victim_way,
    input  logic                                   victim_dirty,
    output logic                                   addr_ok,
    output logic                                   data_ok,
    output dcache_pkg::word_t                      rdata,
    output logic [IDX_W-1:0]                       query_set,
    output logic                                   touch_en,
    output logic [IDX_W-1:0]                       touch_set,
    output logic                                   touch_way,
    output logic                                   mark_dirty,
    ram_port_if.user                               ram_a,
    miss_if.pipe                                   miss
);
    logic                                   st_valid;
    logic                                   st_hit;
    logic                                   st_hit_way;
    logic                                   st_unc;
    dcache_pkg::addr_t                      st_addr;
    dcache_pkg::strb_t                      st_strobe;
    dcache_pkg::word_t                      st_wdata;
    logic [dcache_pkg::WAYS-1:0][TAG_W-1:0] st_tags;
    logic                                   busy;
    logic                                   replay;
    logic                                   unc_resp;
    logic                                   fill_way_r;
    logic                                   accept;
    logic                                   cached_hit;

    assign accept     = req_valid & addr_ok;
    assign cached_hit = st_valid & st_hit & ~st_unc;
    assign miss.start = st_valid & ~cached_hit;
    // falls with the miss in stage, held by busy until done
    assign addr_ok    = ~busy & ~miss.start;

    always_ff @(posedge clk) begin
        if (resetn) begin
            st_valid <= 1'b0;
            busy     <= 1'b0;
            replay   <= 1'b0;
            unc_resp <= 1'b0;
            data_ok  <= 1'b0;
        end else begin
            st_valid <= accept;
            replay   <= miss.done & ~st_unc;
            unc_resp <= miss.done & st_unc;
            data_ok  <= cached_hit | replay | (miss.done & st_unc);
            if (miss.start) begin
                busy <= 1'b1;
            end else if (miss.done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            st_addr    <= req_addr;
            st_strobe  <= req_strobe;
            st_wdata   <= req_wdata;
            st_unc     <= req_uncached;
            st_hit     <= hit;
            st_hit_way <= hit_way;
            st_tags    <= way_tags;
        end
        if (miss.start) begin
            fill_way_r <= victim_way;
        end
    end

    assign query_set  = st_addr[OFF_W +: IDX_W];
    assign touch_set  = st_addr[OFF_W +: IDX_W];
    assign touch_en   = cached_hit;
    assign touch_way  = st_hit_way;
    assign mark_dirty = |st_strobe;

    assign miss.uncached     = st_unc;
    assign miss.addr         = st_addr;
    assign miss.strobe       = st_strobe;
    assign miss.wdata        = st_wdata;
    assign miss.victim_way   = victim_way;
    assign miss.victim_dirty = victim_dirty;
    assign miss.victim_tag   = st_tags[victim_way];

    // replay goes to the way just filled
    assign ram_a.en    = cached_hit | replay;
    assign ram_a.strobe = st_strobe;
    assign ram_a.addr  = {replay ? fill_way_r : st_hit_way,
                          st_addr[OFF_W +: IDX_W], st_addr[2 +: WI]};
    assign ram_a.wdata = st_wdata;

    assign rdata = unc_resp ? miss.unc_rdata : ram_a.rdata;
endmodule

// ==== data_ram.sv ====
`timescale 1ns/100ps

module data_ram #(
    parameter int SET_NUM    = 16,
    parameter int LINE_WORDS = 16
) (
    input logic     clk,
    ram_port_if.ram port_a,
    ram_port_if.ram port_b
);
    // address is {way, set, word}
    localparam int AW = $clog2(dcache_pkg::WAYS) + $clog2(SET_NUM) + $clog2(LINE_WORDS);

    dcache_pkg::word_t mem [2**AW];

    always_ff @(posedge clk) begin
        if (port_a.en) begin
            port_a.rdata <= mem[port_a.addr];
            for (int b = 0; b < dcache_pkg::STRB_BITS; b++) begin
                if (port_a.strobe[b]) begin
                    mem[port_a.addr][8*b +: 8] <= port_a.wdata[8*b +: 8];
                end
            end
        end
        // port b wins on a same-cycle write collision
        if (port_b.en) begin
            port_b.rdata <= mem[port_b.addr];
            for (int b = 0; b < dcache_pkg::STRB_BITS; b++) begin
                if (port_b.strobe[b]) begin
                    mem[port_b.addr][8*b +: 8] <= port_b.wdata[8*b +: 8];
                end
            end
        end
    end
endmodule

// ==== line_state.sv ====
`timescale 1ns/100ps

module line_state #(
    parameter int  SET_NUM = 16,
    localparam int IDX_W   = $clog2(SET_NUM)
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic [IDX_W-1:0] query_set,
    input  logic             touch_en,
    input  logic [IDX_W-1:0] touch_set,
    input  logic             touch_way,
    input  logic             mark_dirty,
    input  logic             fill_en,
    input  logic             fill_way,
    output logic             victim_way,
    output logic             victim_dirty
);
    // plru bit names the way to evict next
    logic [SET_NUM-1:0]                       plru;
    logic [SET_NUM-1:0][dcache_pkg::WAYS-1:0] dirty;

    assign victim_way   = plru[query_set];
    assign victim_dirty = dirty[query_set][victim_way];

    always_ff @(posedge clk) begin
        if (resetn) begin
            plru  <= '0;
            dirty <= '0;
        end else if (fill_en) begin
            plru[touch_set]            <= ~fill_way;
            dirty[touch_set][fill_way] <= mark_dirty;
        end else if (touch_en) begin
            plru[touch_set] <= ~touch_way;
            if (mark_dirty) begin
                dirty[touch_set][touch_way] <= 1'b1;
            end
        end
    end
endmodule

// ==== tag_array.sv ====
`timescale 1ns/100ps

module tag_array #(
    parameter int  SET_NUM    = 16,
    parameter int  LINE_WORDS = 16,
    localparam int OFF_W      = $clog2(LINE_WORDS) + 2,
    localparam int IDX_W      = $clog2(SET_NUM),
    localparam int TAG_W      = dcache_pkg::ADDR_BITS - IDX_W - OFF_W
) (
    input  logic                                      clk,
    input  logic                                      resetn,
    input  dcache_pkg::addr_t                         lookup_addr,
    input  logic                                      fill_en,
    input  dcache_pkg::addr_t                         fill_addr,
    input  logic                                      fill_way,
    output logic                                      hit,
    output logic                                      hit_way,
    output logic [dcache_pkg::WAYS-1:0][TAG_W-1:0]    way_tags
);
    logic [TAG_W-1:0]                         tags [SET_NUM][dcache_pkg::WAYS];
    logic [SET_NUM-1:0][dcache_pkg::WAYS-1:0] valid;
    logic [IDX_W-1:0]                         lk_set;
    logic [IDX_W-1:0]                         fl_set;
    logic [TAG_W-1:0]                         lk_tag;
    logic [dcache_pkg::WAYS-1:0]              match;

    assign lk_set = lookup_addr[OFF_W +: IDX_W];
    assign lk_tag = lookup_addr[dcache_pkg::ADDR_BITS-1 -: TAG_W];
    assign fl_set = fill_addr[OFF_W +: IDX_W];

    always_comb begin
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            way_tags[w] = tags[lk_set][w];
            match[w]    = valid[lk_set][w] && (tags[lk_set][w] == lk_tag);
        end
    end

    assign hit     = |match;
    // two ways only
    assign hit_way = match[1];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[fl_set][fill_way] <= fill_addr[dcache_pkg::ADDR_BITS-1 -: TAG_W];
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[fl_set][fill_way] <= 1'b1;
        end
    end
endmodule

// ==== miss_if.sv ====
`timescale 1ns/100ps

interface miss_if #(
    parameter int TAG_W = 24
);
    logic              start;
    logic              uncached;
    dcache_pkg::addr_t addr;
    dcache_pkg::strb_t strobe;
    dcache_pkg::word_t wdata;
    logic              victim_way;
    logic              victim_dirty;
    logic [TAG_W-1:0]  victim_tag;
    logic              done;
    dcache_pkg::word_t unc_rdata;

    modport pipe (
        output start, uncached, addr, strobe, wdata,
        output victim_way, victim_dirty, victim_tag,
        input  done, unc_rdata
    );

    modport ctrl (
        input  start, uncached, addr, strobe, wdata,
        input  victim_way, victim_dirty, victim_tag,
        output done, unc_rdata
    );
endinterface

// ==== ram_port_if.sv ====
`timescale 1ns/100ps

interface ram_port_if #(
    parameter int AW = 9
);
    logic              en;
    dcache_pkg::strb_t strobe;
    logic [AW-1:0]     addr;
    dcache_pkg::word_t wdata;
    dcache_pkg::word_t rdata;

    modport user (
        output en, strobe, addr, wdata,
        input  rdata
    );

    modport ram (
        input  en, strobe, addr, wdata,
        output rdata
    );
endinterface

// ==== dcache_pkg.sv ====
package dcache_pkg;

    localparam int ADDR_BITS = 32;
    localparam int WORD_BITS = 32;
    localparam int STRB_BITS = 4;

    // plru holds a single bit per set
    localparam int WAYS = 2;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [STRB_BITS-1:0] strb_t;

    typedef enum logic {
        LEN_SINGLE,
        LEN_LINE
    } burst_len_t;

    typedef enum logic [2:0] {
        IDLE,
        WB_READ,
        WRITEBACK,
        FETCH,
        UNCACHED
    } miss_state_t;

endpackage
